/* sources.f */
+incdir+bench
source/regmap_pkg.sv
source/bus_pkg.sv
source/axil_reg_bank.sv
source/portion_tracker.sv
source/event_queue.sv
source/stream_event_writer.sv
bench/tb_stream_event_writer.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_stream_event_writer
RTL_TOP  = stream_event_writer
FILELIST = sources.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/tb_tasks.svh */
task automatic timeout_fail(input string what);
    $display("Timeout while waiting for %s", what);
    errors++;
endtask

task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else begin
        $display("** Error: %s is 0x%08h, expected 0x%08h", name, got, exp);
        errors++;
    end
endtask

task automatic axil_write(input logic [3:0] idx, input logic [31:0] data);
    int t;
    t = 0;
    @(posedge aclk);
    axil_req.awaddr  <= {idx, 2'b00};
    axil_req.wdata   <= data;
    axil_req.wstrb   <= 4'hf;
    axil_req.awvalid <= 1'b1;
    axil_req.wvalid  <= 1'b1;
    @(negedge aclk);
    while (!axil_rsp.awready && t < tmo) begin
        @(negedge aclk);
        t++;
    end
    if (!axil_rsp.awready)
        timeout_fail("the write address handshake");
    @(posedge aclk);
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    t = 0;
    @(negedge aclk);
    while (!axil_rsp.bvalid && t < tmo) begin
        @(negedge aclk);
        t++;
    end
    if (!axil_rsp.bvalid)
        timeout_fail("the write response");
    else
        check_val("bresp", 32'(axil_rsp.bresp), 32'd0);   // Always OKAY
    @(posedge aclk);
endtask

task automatic axil_read(input logic [3:0] idx, output logic [31:0] data, output logic [1:0] resp);
    int t;
    t = 0;
    @(posedge aclk);
    axil_req.araddr  <= {idx, 2'b00};
    axil_req.arvalid <= 1'b1;
    @(negedge aclk);
    while (!axil_rsp.arready && t < tmo) begin
        @(negedge aclk);
        t++;
    end
    if (!axil_rsp.arready)
        timeout_fail("the read address handshake");
    @(posedge aclk);
    axil_req.arvalid <= 1'b0;
    t = 0;
    @(negedge aclk);
    while (!axil_rsp.rvalid && t < tmo) begin
        @(negedge aclk);
        t++;
    end
    if (!axil_rsp.rvalid)
        timeout_fail("the read data");
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    @(posedge aclk);
endtask

// Reference model of portions and the record FIFO
task automatic model_push(input logic [31:0] addr, input logic [31:0] bytes);
    bus_pkg::portion_rec_t r;
    logic [32:0] nxt;
    r.addr  = addr;
    r.bytes = bytes;
    produced++;
    if (model_q.size() == regmap_pkg::queue_depth)
        model_ovf = 1'b1;       // Dropped
    else
        model_q.push_back(r);
    nxt = {1'b0, addr + bytes} + {1'b0, model_ps};
    model_base = (nxt > {1'b0, model_high}) ? model_start : addr + bytes;
    model_cnt  = 0;
endtask

task automatic model_beat(input logic last);
    model_cnt = model_cnt + 32'd4;
    if (model_cnt >= model_ps || last)
        model_push(model_base, model_cnt);
endtask

task automatic model_stop();
    if (model_cnt != 0)
        model_push(model_base, model_cnt);
    model_run = 1'b0;
endtask

// One clock of stream stimulus, with optional external acks
task automatic drive_cycle(input bit stream_on, input bit acks_on);
    @(posedge aclk);
    user_event_ack <= ack_next;
    ack_next = 1'b0;
    s_axis.tvalid <= stream_on && ($urandom % 4 != 0);
    s_axis.tdata  <= $urandom;
    s_axis.tlast  <= stream_on && ($urandom % 8 == 0);
    @(negedge aclk);
    check_val("s_axis_tready", 32'(s_axis_tready), 32'(model_run));
    if (s_axis.tvalid && model_run)
        model_beat(s_axis.tlast);
    if (holdoff > 0) begin
        holdoff--;
    end else if (acks_on && user_event) begin
        assert (model_q.size() != 0)
        else begin
            $display("user_event is high while the model queue is empty");
            errors++;
        end
        if (model_q.size() != 0) begin
            check_val("current_addr", current_addr, model_q[0].addr);
            check_val("transmitted_bytes", transmitted_bytes, model_q[0].bytes);
            void'(model_q.pop_front());
        end
        ack_next = 1'b1;
        holdoff  = 5;       // Pop lands a few cycles later
    end
endtask

task automatic drain_queue();
    int t;
    t = 0;
    while ((model_q.size() != 0 || user_event || holdoff != 0) && t < tmo) begin
        drive_cycle(1'b0, 1'b1);
        t++;
    end
    if (t == tmo)
        timeout_fail("the queue to drain");
endtask

/* bench/tb_stream_event_writer.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_stream_event_writer;

    localparam int tmo = 5000;

    logic                   aclk = 1'b0;
    logic                   aresetn;
    bus_pkg::axil_req_t     axil_req;
    bus_pkg::axil_rsp_t     axil_rsp;
    bus_pkg::stream_beat_t  s_axis;
    logic                   s_axis_tready;
    logic                   user_event_ack;
    logic                   user_event;
    logic [31:0]            current_addr;
    logic [31:0]            transmitted_bytes;

    int  errors = 0;
    int  checks = 0;
    int  holdoff = 0;
    int  produced = 0;
    bit  ack_next = 1'b0;
    bit  model_ovf = 1'b0;
    bit  model_run = 1'b0;
    logic [31:0] model_base, model_cnt, model_ps, model_start, model_high;
    bus_pkg::portion_rec_t model_q[$];

    always #50 aclk = ~aclk;

    stream_event_writer i_dut (
        .aclk              (aclk),
        .aresetn           (aresetn),
        .axil_req          (axil_req),
        .axil_rsp          (axil_rsp),
        .s_axis            (s_axis),
        .s_axis_tready     (s_axis_tready),
        .user_event_ack    (user_event_ack),
        .user_event        (user_event),
        .current_addr      (current_addr),
        .transmitted_bytes (transmitted_bytes)
    );

    `include "tb_tasks.svh"

    task automatic configure(input logic [31:0] ps, input logic [31:0] start,
                             input logic [31:0] high);
        axil_write(4'd2, ps);
        axil_write(4'd3, high);
        axil_write(4'd7, start);
        model_ps    = ps;
        model_start = start;
        model_high  = high;
    endtask

    task automatic start_run(input logic [31:0] ctrl_word);
        model_base = model_start;
        model_cnt  = 0;
        produced   = 0;
        axil_write(4'd1, ctrl_word | 32'd1);
        model_run  = 1'b1;
    endtask

    task automatic stream_until(input int n);
        int t;
        t = 0;
        while (produced < n && t < tmo) begin
            drive_cycle(1'b1, 1'b0);
            t++;
        end
        if (produced < n)
            timeout_fail("portions to close");
        drive_cycle(1'b0, 1'b0);
    endtask

    task automatic settle();
        repeat (6) @(posedge aclk);
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] v;
        logic [1:0]  resp;
        int t;
        v = $urandom(29307);
        axil_req = '0;
        axil_req.bready = 1'b1;
        axil_req.rready = 1'b1;
        s_axis = '0;
        user_event_ack = 1'b0;
        aresetn = 1'b0;
        repeat (10) @(posedge aclk);
        aresetn <= 1'b1;
        repeat (regmap_pkg::func_reset_cycles + 2) @(posedge aclk);

        // Reset values
        axil_read(4'd2, rd, resp);
        check_val("reg_portion", rd, regmap_pkg::default_portion_size);
        axil_read(4'd3, rd, resp);
        check_val("reg_high", rd, regmap_pkg::default_high_addr);
        axil_read(4'd7, rd, resp);
        check_val("reg_start", rd, regmap_pkg::default_start_addr);
        axil_read(4'd5, rd, resp);
        check_val("reg_freq", rd, regmap_pkg::freq_hz);
        axil_read(4'd1, rd, resp);
        check_val("reg_ctrl", rd, 32'd0);
        check_val("user_event", 32'(user_event), 32'd0);

        // Random register values
        for (int r = 0; r < 3; r++) begin
            v = $urandom;
            axil_write(r == 0 ? 4'd2 : r == 1 ? 4'd3 : 4'd7, v);
            axil_read(r == 0 ? 4'd2 : r == 1 ? 4'd3 : 4'd7, rd, resp);
            check_val("register readback", rd, v);
        end
        axil_read(4'd13, rd, resp);
        check_val("rresp", 32'(resp), 32'd2);

        // External ack mode, stream paused before the queue gets near full
        configure(32'd4 * (32'd2 + ($urandom % 8)), 32'h100, 32'h180);
        start_run(32'd0);
        repeat (400) drive_cycle(model_q.size() < regmap_pkg::queue_depth - 4, 1'b1);
        drive_cycle(1'b0, 1'b1);
        axil_write(4'd1, 32'd0);
        model_stop();
        drain_queue();
        axil_read(4'd11, rd, resp);
        check_val("reg_volume", rd, 32'd0);
        check_val("user_event", 32'(user_event), 32'd0);

        // Overflow with no acks
        configure(32'd8, 32'h200, 32'h300);
        model_ovf = 1'b0;
        start_run(32'd0);
        stream_until(regmap_pkg::queue_depth + 4);
        axil_write(4'd1, 32'd0);
        model_stop();
        settle();
        axil_read(4'd11, rd, resp);
        check_val("reg_volume", rd, 32'(regmap_pkg::queue_depth));
        axil_read(4'd1, rd, resp);
        check_val("reg_ctrl overflow", 32'(rd[9]), 32'(model_ovf));
        drain_queue();
        axil_write(4'd1, 32'h200);
        axil_read(4'd1, rd, resp);
        check_val("reg_ctrl overflow", 32'(rd[9]), 32'd0);

        // Ack by register write
        configure(32'd16, 32'h0, 32'h100);
        start_run(32'h0100_0000);
        stream_until(3);
        axil_write(4'd1, 32'h0100_0000);
        model_stop();
        settle();
        t = 0;
        while (model_q.size() != 0 && t < 40) begin
            axil_read(4'd8, rd, resp);
            check_val("reg_head_addr", rd, model_q[0].addr);
            axil_read(4'd10, rd, resp);
            check_val("reg_head_bytes", rd, model_q[0].bytes);
            axil_read(4'd11, rd, resp);
            check_val("reg_volume", rd, 32'(model_q.size()));
            axil_write(4'd1, 32'h0100_0100);
            void'(model_q.pop_front());
            settle();
            t++;
        end
        axil_read(4'd11, rd, resp);
        check_val("reg_volume", rd, 32'd0);

        // Ack by head read
        start_run(32'h0200_0000);
        stream_until(3);
        axil_write(4'd1, 32'h0200_0000);
        model_stop();
        settle();
        t = 0;
        while (model_q.size() != 0 && t < 40) begin
            axil_read(4'd8, rd, resp);
            check_val("reg_head_addr", rd, model_q[0].addr);
            void'(model_q.pop_front());
            settle();
            t++;
        end
        axil_read(4'd11, rd, resp);
        check_val("reg_volume", rd, 32'd0);

        // Soft reset in the middle of a run
        start_run(32'd0);
        stream_until(3);
        axil_write(4'd0, 32'd1);
        model_q.delete();
        model_run = 1'b0;
        t = 0;
        rd = 32'hffff_ffff;
        while (rd != 0 && t < 50) begin
            axil_read(4'd1, v, resp);
            axil_read(4'd11, rd, resp);
            rd = rd | 32'(v[16]);
            t++;
        end
        if (rd != 0)
            timeout_fail("the soft reset to finish");
        axil_read(4'd1, rd, resp);
        check_val("reg_ctrl status", 32'(rd[16]), 32'd0);
        axil_read(4'd11, rd, resp);
        check_val("reg_volume", rd, 32'd0);
        check_val("user_event", 32'(user_event), 32'd0);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

/* source/stream_event_writer.sv */
`timescale 1ns/100ps
`default_nettype none

module stream_event_writer (
    input  wire logic                    aclk,
    input  wire logic                    aresetn,
    input  wire bus_pkg::axil_req_t      axil_req,
    output bus_pkg::axil_rsp_t           axil_rsp,
    input  wire bus_pkg::stream_beat_t   s_axis,
    output logic                         s_axis_tready,
    input  wire logic                    user_event_ack,
    output logic                         user_event,
    output logic [regmap_pkg::addr_w-1:0] current_addr,
    output logic [31:0]                  transmitted_bytes
);

    bus_pkg::writer_cfg_t   cfg;
    bus_pkg::ctrl_pulse_t   ctrl;
    bus_pkg::queue_status_t qstat;
    bus_pkg::portion_rec_t  rec;
    logic                   rec_valid;
    logic                   running;

    axil_reg_bank i_reg_bank (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .running  (running),
        .qstat    (qstat),
        .cfg      (cfg),
        .ctrl     (ctrl)
    );

    portion_tracker i_tracker (
        .aclk       (aclk),
        .func_reset (ctrl.func_reset),
        .cfg        (cfg),
        .run        (ctrl.run),
        .stop       (ctrl.stop),
        .beat       (s_axis),
        .tready     (s_axis_tready),
        .running    (running),
        .rec        (rec),
        .rec_valid  (rec_valid)
    );

    event_queue #(
        .depth (regmap_pkg::queue_depth)
    ) i_queue (
        .aclk           (aclk),
        .func_reset     (ctrl.func_reset),
        .rec            (rec),
        .rec_valid      (rec_valid),
        .ack_src        (cfg.ack_src),
        .ctrl           (ctrl),
        .user_event_ack (user_event_ack),
        .qstat          (qstat),
        .user_event     (user_event)
    );

    // Head record of the queue
    assign current_addr      = qstat.head.addr;
    assign transmitted_bytes = qstat.head.bytes;

endmodule

`default_nettype wire

/* source/event_queue.sv */
`timescale 1ns/100ps
`default_nettype none

module event_queue #(
    parameter int depth = regmap_pkg::queue_depth   // Power of two
) (
    input  wire logic                  aclk,
    input  wire logic                  func_reset,
    input  wire bus_pkg::portion_rec_t rec,
    input  wire logic                  rec_valid,
    input  wire regmap_pkg::ack_src_e  ack_src,
    input  wire bus_pkg::ctrl_pulse_t  ctrl,
    input  wire logic                  user_event_ack,
    output bus_pkg::queue_status_t     qstat,
    output logic                       user_event
);

    localparam int ptr_w = $clog2(depth);

    bus_pkg::portion_rec_t mem [depth];
    logic [ptr_w-1:0]      wr_ptr;
    logic [ptr_w-1:0]      rd_ptr;
    logic [ptr_w:0]        count;
    logic                  ack_d;
    logic                  ack_rise;
    logic                  ack_sel;
    logic                  full;
    logic                  push;
    logic                  pop;
    logic                  overflow;

    assign ack_rise = user_event_ack && !ack_d;
    assign full     = count == (ptr_w + 1)'(depth);
    assign push     = rec_valid && !full;
    assign pop      = ack_sel && count != '0;

    always_ff @(posedge aclk) begin
        if (func_reset) begin
            ack_d   <= 1'b0;
            ack_sel <= 1'b0;
        end else begin
            ack_d <= user_event_ack;
            case (ack_src)
                regmap_pkg::ack_reg_write: ack_sel <= ctrl.irq_ack;
                regmap_pkg::ack_head_read: ack_sel <= ctrl.head_read;
                default:                   ack_sel <= ack_rise;    // External edge
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (push)
            mem[wr_ptr] <= rec;
    end

    always_ff @(posedge aclk) begin
        if (func_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Sticky until acked, a push in the ack cycle wins
    always_ff @(posedge aclk) begin
        if (func_reset)
            overflow <= 1'b0;
        else if (rec_valid) begin
            if (full)
                overflow <= 1'b1;
        end else if (ctrl.ovf_ack) begin
            overflow <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (func_reset)
            user_event <= 1'b0;
        else
            user_event <= qstat.not_empty;
    end

    assign qstat = '{
        head:      mem[rd_ptr],
        not_empty: count != '0,
        overflow:  overflow,
        volume:    32'(count)
    };

endmodule

`default_nettype wire

/* source/portion_tracker.sv */
`timescale 1ns/100ps
`default_nettype none

module portion_tracker (
    input  wire logic                   aclk,
    input  wire logic                   func_reset,
    input  wire bus_pkg::writer_cfg_t   cfg,
    input  wire logic                   run,
    input  wire logic                   stop,
    input  wire bus_pkg::stream_beat_t  beat,
    output logic                        tready,
    output logic                        running,
    output bus_pkg::portion_rec_t       rec,
    output logic                        rec_valid
);

    typedef enum logic {
        tr_idle,
        tr_run
    } tracker_state_e;

    tracker_state_e                state;
    logic [31:0]                   byte_cnt;
    logic [31:0]                   cnt_acc;
    logic [regmap_pkg::addr_w-1:0] base_addr;
    logic [regmap_pkg::addr_w-1:0] sum_addr;
    logic                          accept;
    logic                          emit;
    logic                          wrap;

    assign running = state == tr_run;
    assign tready  = running;          // No back-pressure
    assign accept  = beat.tvalid && tready;

    always_comb begin
        cnt_acc  = accept ? byte_cnt + regmap_pkg::n_bytes : byte_cnt;
        emit     = running && ((accept && (cnt_acc >= cfg.portion_size || beat.tlast))
                   || (stop && cnt_acc != 32'd0));
        sum_addr = base_addr + cnt_acc;
        // Next portion must fit below the high address
        wrap     = {1'b0, sum_addr} + {1'b0, cfg.portion_size} > {1'b0, cfg.high_addr};
    end

    always_ff @(posedge aclk) begin
        if (func_reset) begin
            state     <= tr_idle;
            byte_cnt  <= '0;
            rec_valid <= 1'b0;
        end else begin
            rec_valid <= emit;
            case (state)
                tr_idle: begin
                    if (run) begin
                        state    <= tr_run;
                        byte_cnt <= '0;
                    end
                end
                tr_run: begin
                    byte_cnt <= emit ? 32'd0 : cnt_acc;
                    if (stop)
                        state <= tr_idle;
                end
                default: state <= tr_idle;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (emit) begin
            rec.addr  <= base_addr;
            rec.bytes <= cnt_acc;
        end
        if (state == tr_idle && run)
            base_addr <= cfg.start_addr;
        else if (emit)
            base_addr <= wrap ? cfg.start_addr : sum_addr;
    end

endmodule

`default_nettype wire

/* source/axil_reg_bank.sv */
`timescale 1ns/100ps
`default_nettype none

module axil_reg_bank (
    input  wire logic                  aclk,
    input  wire logic                  aresetn,
    input  wire bus_pkg::axil_req_t    axil_req,
    output bus_pkg::axil_rsp_t         axil_rsp,
    input  wire logic                  running,
    input  wire bus_pkg::queue_status_t qstat,
    output bus_pkg::writer_cfg_t       cfg,
    output bus_pkg::ctrl_pulse_t       ctrl
);

    localparam int rst_w = $clog2(regmap_pkg::func_reset_cycles + 1);

    logic                            wr_ready;
    logic                            bvalid;
    logic                            rd_ready;
    logic                            rvalid;
    logic [31:0]                     rdata;
    logic [1:0]                      rresp;
    logic                            wr_hs;
    logic                            rd_hs;
    logic                            wr_ctrl;
    logic [regmap_pkg::reg_idx_w-1:0] wr_idx;
    logic [regmap_pkg::reg_idx_w-1:0] rd_idx;
    logic [31:0]                     wdata;
    logic [3:0]                      wstrb;
    logic [31:0]                     rd_word;

    logic [31:0] reset_reg;
    logic [31:0] ctrl_reg;
    logic [31:0] portion_reg;
    logic [31:0] high_reg;
    logic [31:0] start_reg;

    logic             func_reset;
    logic [rst_w-1:0] rst_cnt;
    logic             run_p;
    logic             stop_p;
    logic             irq_ack_p;
    logic             ovf_ack_p;
    logic             head_read_p;

    function automatic logic [31:0] strobed(
        input logic [31:0] old,
        input logic [31:0] data,
        input logic [3:0]  strb
    );
        logic [31:0] res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i])
                res[8*i +: 8] = data[8*i +: 8];
        end
        return res;
    endfunction

    assign wdata   = axil_req.wdata;
    assign wstrb   = axil_req.wstrb;
    assign wr_idx  = axil_req.awaddr[2 +: regmap_pkg::reg_idx_w];
    assign rd_idx  = axil_req.araddr[2 +: regmap_pkg::reg_idx_w];
    assign wr_hs   = wr_ready && axil_req.awvalid && axil_req.wvalid;
    assign rd_hs   = rd_ready && axil_req.arvalid;
    assign wr_ctrl = wr_hs && wr_idx == regmap_pkg::reg_ctrl;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ready <= 1'b0;
            bvalid   <= 1'b0;
        end else begin
            wr_ready <= !wr_ready && axil_req.awvalid && axil_req.wvalid && !bvalid;
            if (wr_hs)
                bvalid <= 1'b1;
            else if (axil_req.bready)
                bvalid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            rd_ready <= 1'b0;
            rvalid   <= 1'b0;
            rresp    <= 2'b00;
        end else begin
            rd_ready <= !rd_ready && axil_req.arvalid && !rvalid;
            if (rd_hs) begin
                rvalid <= 1'b1;
                rresp  <= (rd_idx < regmap_pkg::reg_count) ? 2'b00 : 2'b10;
            end else if (axil_req.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (rd_hs && rd_idx < regmap_pkg::reg_count)
            rdata <= rd_word;   // Unmapped index keeps old data
    end

    always_comb begin
        case (rd_idx)
            regmap_pkg::reg_reset:      rd_word = reset_reg;
            regmap_pkg::reg_ctrl: begin
                rd_word = ctrl_reg;
                rd_word[regmap_pkg::ctrl_status_bit] = running;
                rd_word[regmap_pkg::ctrl_ovf_bit]    = qstat.overflow;
            end
            regmap_pkg::reg_portion:    rd_word = portion_reg;
            regmap_pkg::reg_high:       rd_word = high_reg;
            regmap_pkg::reg_freq:       rd_word = regmap_pkg::freq_hz;
            regmap_pkg::reg_start:      rd_word = start_reg;
            regmap_pkg::reg_head_addr:  rd_word = qstat.head.addr;
            regmap_pkg::reg_head_bytes: rd_word = qstat.head.bytes;
            regmap_pkg::reg_volume:     rd_word = qstat.volume;
            regmap_pkg::reg_interval,
            regmap_pkg::reg_valid,
            regmap_pkg::reg_duration:   rd_word = 32'd0;
            default:                    rd_word = 32'd0;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            reset_reg   <= '0;
            ctrl_reg    <= '0;
            portion_reg <= regmap_pkg::default_portion_size;
            high_reg    <= regmap_pkg::default_high_addr;
            start_reg   <= regmap_pkg::default_start_addr;
        end else if (wr_hs) begin
            case (wr_idx)
                regmap_pkg::reg_reset:   reset_reg   <= strobed(reset_reg, wdata, wstrb);
                regmap_pkg::reg_ctrl:    ctrl_reg    <= strobed(ctrl_reg, wdata, wstrb);
                regmap_pkg::reg_portion: portion_reg <= strobed(portion_reg, wdata, wstrb);
                regmap_pkg::reg_high:    high_reg    <= strobed(high_reg, wdata, wstrb);
                regmap_pkg::reg_start:   start_reg   <= strobed(start_reg, wdata, wstrb);
                default: ;
            endcase
        end
    end

    // Soft reset, restarted by bit 0 of register 0
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            rst_cnt    <= '0;
            func_reset <= 1'b1;
        end else if (wr_hs && wr_idx == regmap_pkg::reg_reset && wdata[0]) begin
            rst_cnt    <= '0;
            func_reset <= 1'b1;
        end else if (rst_cnt != rst_w'(regmap_pkg::func_reset_cycles)) begin
            rst_cnt    <= rst_cnt + 1'b1;
            func_reset <= 1'b1;
        end else begin
            func_reset <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn || func_reset) begin
            run_p  <= 1'b0;
            stop_p <= 1'b0;
        end else begin
            run_p  <= wr_ctrl && wdata[regmap_pkg::ctrl_run_bit];
            stop_p <= wr_ctrl && !wdata[regmap_pkg::ctrl_run_bit];
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            irq_ack_p   <= 1'b0;
            ovf_ack_p   <= 1'b0;
            head_read_p <= 1'b0;
        end else begin
            irq_ack_p   <= wr_ctrl && wdata[regmap_pkg::ctrl_irq_ack_bit];
            ovf_ack_p   <= wr_ctrl && wdata[regmap_pkg::ctrl_ovf_bit];
            head_read_p <= rd_hs && rd_idx == regmap_pkg::reg_head_addr;
        end
    end

    assign axil_rsp = '{
        awready: wr_ready,
        wready:  wr_ready,
        bresp:   2'b00,
        bvalid:  bvalid,
        arready: rd_ready,
        rdata:   rdata,
        rresp:   rresp,
        rvalid:  rvalid
    };

    assign cfg = '{
        portion_size: portion_reg,
        start_addr:   start_reg[regmap_pkg::addr_w-1:0],
        high_addr:    high_reg[regmap_pkg::addr_w-1:0],
        ack_src:      regmap_pkg::ack_src_e'(ctrl_reg[regmap_pkg::ctrl_ack_src_lsb +: 2])
    };

    assign ctrl = '{
        func_reset: func_reset,
        run:        run_p,
        stop:       stop_p,
        irq_ack:    irq_ack_p,
        ovf_ack:    ovf_ack_p,
        head_read:  head_read_p
    };

endmodule

`default_nettype wire

/* source/bus_pkg.sv */
`default_nettype none

package bus_pkg;

    typedef struct packed {
        logic [5:0]  awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [5:0]  araddr;
        logic        arvalid;
        logic        rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic [1:0]  bresp;
        logic        bvalid;
        logic        arready;
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        rvalid;
    } axil_rsp_t;

    typedef struct packed {
        logic [regmap_pkg::data_w-1:0] tdata;
        logic                          tvalid;
        logic                          tlast;
    } stream_beat_t;

    typedef struct packed {
        logic [31:0]                   portion_size;
        logic [regmap_pkg::addr_w-1:0] start_addr;
        logic [regmap_pkg::addr_w-1:0] high_addr;
        regmap_pkg::ack_src_e          ack_src;
    } writer_cfg_t;

    typedef struct packed {
        logic func_reset;   // Multi-cycle
        logic run;
        logic stop;
        logic irq_ack;
        logic ovf_ack;
        logic head_read;
    } ctrl_pulse_t;

    typedef struct packed {
        logic [regmap_pkg::addr_w-1:0] addr;
        logic [31:0]                   bytes;
    } portion_rec_t;

    typedef struct packed {
        portion_rec_t head;
        logic         not_empty;
        logic         overflow;
        logic [31:0]  volume;
    } queue_status_t;

endpackage

`default_nettype wire

/* source/regmap_pkg.sv */
`default_nettype none

package regmap_pkg;

    localparam int n_bytes   = 4;             // Bytes per stream beat
    localparam int data_w    = n_bytes * 8;
    localparam int addr_w    = 32;
    localparam int reg_idx_w = 4;             // Word address bits 5:2
    localparam int reg_count = 12;

    localparam int queue_depth       = 16;
    localparam int func_reset_cycles = 5;

    localparam logic [31:0] freq_hz              = 32'd250_000_000;
    localparam logic [31:0] default_portion_size = 32'd64;
    localparam logic [31:0] default_high_addr    = 32'h0000_1000;
    localparam logic [31:0] default_start_addr   = 32'h0000_0000;

    // Register 1 layout
    localparam int ctrl_run_bit     = 0;
    localparam int ctrl_irq_ack_bit = 8;
    localparam int ctrl_ovf_bit     = 9;      // Ack on write, sticky flag on read
    localparam int ctrl_status_bit  = 16;
    localparam int ctrl_ack_src_lsb = 24;

    typedef enum logic [reg_idx_w-1:0] {
        reg_reset,
        reg_ctrl,
        reg_portion,
        reg_high,
        reg_interval,
        reg_freq,
        reg_valid,
        reg_start,
        reg_head_addr,
        reg_duration,
        reg_head_bytes,
        reg_volume
    } reg_idx_e;

    typedef enum logic [1:0] {
        ack_ext       = 2'd0,
        ack_reg_write = 2'd1,
        ack_head_read = 2'd2
    } ack_src_e;

endpackage

`default_nettype wire
